//--- dv/csr_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

module csr_unit_tb;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] rs1_value;
    logic        trap_req;
    logic [31:0] trap_cause;
    logic [31:0] trap_pc;
    logic [31:0] trap_tval;
    logic [31:0] rdata;
    logic        rdata_valid;
    logic        illegal;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    integer seed = 32'h6605_e8ab;

    // shadow copy of the writable csrs
    logic [31:0] sh_mstatus;
    logic [31:0] sh_mie;
    logic [31:0] sh_mtvec;
    logic [31:0] sh_mcounteren;
    logic [31:0] sh_mscratch;
    logic [31:0] sh_mepc;
    logic [31:0] sh_mcause;
    logic [31:0] sh_mtval;

    logic [31:0] exp_rdata_q[$];
    logic        exp_illegal_q[$];
    int          checked = 0;

    logic [11:0] id_addrs[$] = '{csr_pkg::addr_mvendorid, csr_pkg::addr_marchid,
        csr_pkg::addr_mimpid, csr_pkg::addr_mhartid, csr_pkg::addr_mstatus,
        csr_pkg::addr_misa, csr_pkg::addr_mie, csr_pkg::addr_mtvec,
        csr_pkg::addr_mcounteren, csr_pkg::addr_mscratch, csr_pkg::addr_mepc,
        csr_pkg::addr_mcause, csr_pkg::addr_mtval, csr_pkg::addr_mip};
    logic [2:0]  csr_funct3s[$] = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};

    csr_unit uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .rs1_value      (rs1_value),
        .trap_req       (trap_req),
        .trap_cause     (trap_cause),
        .trap_pc        (trap_pc),
        .trap_tval      (trap_tval),
        .rdata          (rdata),
        .rdata_valid    (rdata_valid),
        .illegal        (illegal),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        stop_with_failure($sformatf("MISMATCH at %0t: %s got 0x%08h expected 0x%08h",
                                    $time, name, got, expected));
    endtask

    ////////////////////////////////////////////////////////////
    // latency checks
    ////////////////////////////////////////////////////////////

    logic csr_in;
    logic mret_in;
    logic csr_d1;
    logic csr_d2;
    logic redir_d1;
    logic redir_d2;

    // funct3 1-3 and 5-7 are csr ops
    assign csr_in  = instr_valid && (instr[6:0] == csr_pkg::opcode_system) &&
                     (instr[13:12] != 2'b00);
    assign mret_in = instr_valid && (instr == csr_pkg::mret_instr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csr_d1   <= 1'b0;
            csr_d2   <= 1'b0;
            redir_d1 <= 1'b0;
            redir_d2 <= 1'b0;
        end else begin
            csr_d1   <= csr_in;
            csr_d2   <= csr_d1;
            redir_d1 <= trap_req || mret_in;
            redir_d2 <= redir_d1;
        end
    end

    a_rdata_latency: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid == csr_d2)
        else report_mismatch("rdata_valid", {31'd0, $sampled(rdata_valid)},
                             {31'd0, $sampled(csr_d2)});

    a_redirect_latency: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid == redir_d2)
        else report_mismatch("redirect_valid", {31'd0, $sampled(redirect_valid)},
                             {31'd0, $sampled(redir_d2)});

    a_illegal_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        illegal |-> rdata_valid)
        else stop_with_failure("illegal was raised without rdata_valid");

    // read results in issue order
    always @(negedge clk) begin
        if (rst_n && rdata_valid) begin
            if (checked >= exp_rdata_q.size()) begin
                stop_with_failure("rdata_valid arrived with no instruction outstanding");
            end else begin
                assert (rdata == exp_rdata_q[checked])
                    else report_mismatch("rdata", rdata, exp_rdata_q[checked]);
                assert (illegal == exp_illegal_q[checked])
                    else report_mismatch("illegal", {31'd0, illegal},
                                         {31'd0, exp_illegal_q[checked]});
                checked = checked + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // shadow model
    ////////////////////////////////////////////////////////////

    function automatic logic addr_is_known(input logic [11:0] a);
        return (a inside {csr_pkg::addr_mvendorid, csr_pkg::addr_marchid,
                          csr_pkg::addr_mimpid, csr_pkg::addr_mhartid,
                          csr_pkg::addr_mstatus, csr_pkg::addr_misa, csr_pkg::addr_mie,
                          csr_pkg::addr_mtvec, csr_pkg::addr_mcounteren,
                          csr_pkg::addr_mscratch, csr_pkg::addr_mepc, csr_pkg::addr_mcause,
                          csr_pkg::addr_mtval, csr_pkg::addr_mip});
    endfunction

    function automatic logic addr_is_ro(input logic [11:0] a);
        return (a inside {csr_pkg::addr_mvendorid, csr_pkg::addr_marchid,
                          csr_pkg::addr_mimpid, csr_pkg::addr_mhartid});
    endfunction

    function automatic logic [31:0] shadow_read(input logic [11:0] a);
        case (a)
            csr_pkg::addr_mvendorid:  return csr_pkg::mvendorid_val;
            csr_pkg::addr_marchid:    return csr_pkg::marchid_val;
            csr_pkg::addr_mimpid:     return csr_pkg::mimpid_val;
            csr_pkg::addr_mhartid:    return csr_pkg::mhartid_val;
            csr_pkg::addr_misa:       return csr_pkg::misa_val;
            csr_pkg::addr_mstatus:    return sh_mstatus;
            csr_pkg::addr_mie:        return sh_mie;
            csr_pkg::addr_mtvec:      return sh_mtvec;
            csr_pkg::addr_mcounteren: return sh_mcounteren;
            csr_pkg::addr_mscratch:   return sh_mscratch;
            csr_pkg::addr_mepc:       return sh_mepc;
            csr_pkg::addr_mcause:     return sh_mcause;
            csr_pkg::addr_mtval:      return sh_mtval;
            default:                  return 32'd0;
        endcase
    endfunction

    // mpp stays machine mode whatever is written
    function automatic void shadow_write(input logic [11:0] a, input logic [31:0] v);
        case (a)
            csr_pkg::addr_mstatus:
                sh_mstatus = (v & csr_pkg::mstatus_wmask) |
                             {19'd0, csr_pkg::mstatus_mpp_m, 11'd0};
            csr_pkg::addr_mie:        sh_mie = v;
            csr_pkg::addr_mtvec:      sh_mtvec = v & csr_pkg::mtvec_wmask;
            csr_pkg::addr_mcounteren: sh_mcounteren = v;
            csr_pkg::addr_mscratch:   sh_mscratch = v;
            csr_pkg::addr_mepc:       sh_mepc = {v[31:2], 2'b00};
            csr_pkg::addr_mcause:     sh_mcause = v;
            csr_pkg::addr_mtval:      sh_mtval = v;
            default:                  ;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic issue_csr(input logic [2:0] funct3, input logic [11:0] a,
                             input logic [4:0] rs1f, input logic [31:0] rs1v);
        logic [31:0] operand;
        logic [31:0] old;
        logic [31:0] nv;
        logic        write;
        logic        legal;
        operand = funct3[2] ? {27'd0, rs1f} : rs1v;
        write   = (funct3[1:0] == 2'b01) || (rs1f != 5'd0);
        legal   = addr_is_known(a) && !(addr_is_ro(a) && write);
        old     = legal ? shadow_read(a) : 32'd0;
        case (funct3[1:0])
            2'b01:   nv = operand;
            2'b10:   nv = old | operand;
            default: nv = old & ~operand;
        endcase
        if (legal && write)
            shadow_write(a, nv);
        exp_rdata_q.push_back(old);
        exp_illegal_q.push_back(!legal);
        instr_valid = 1'b1;
        instr       = {a, rs1f, funct3, 5'd10, csr_pkg::opcode_system};
        rs1_value   = rs1v;
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic drain_reads();
        int cycles;
        cycles = 0;
        while (checked != exp_rdata_q.size()) begin
            @(negedge clk);
            cycles++;
            if (cycles > 16)
                stop_with_failure("read results still missing after 16 cycles");
        end
    endtask

    task automatic wait_redirect(input logic [31:0] exp_pc);
        int cycles;
        cycles = 0;
        while (!redirect_valid) begin
            @(negedge clk);
            cycles++;
            if (cycles > 8)
                stop_with_failure("no redirect within 8 cycles");
        end
        assert (redirect_pc == exp_pc)
            else report_mismatch("redirect_pc", redirect_pc, exp_pc);
        @(negedge clk);
    endtask

    task automatic raise_trap(input logic [31:0] cause, input logic [31:0] pc,
                              input logic [31:0] tval);
        logic [31:0] target;
        target = {sh_mtvec[31:2], 2'b00};
        // vectored interrupts land at base plus four times the code
        if (sh_mtvec[0] && cause[31])
            target = target + ((cause & 32'h7fff_ffff) << 2);
        sh_mepc   = {pc[31:2], 2'b00};
        sh_mcause = cause;
        sh_mtval  = tval;
        sh_mstatus[csr_pkg::mstatus_mpie] = sh_mstatus[csr_pkg::mstatus_mie];
        sh_mstatus[csr_pkg::mstatus_mie]  = 1'b0;
        trap_req   = 1'b1;
        trap_cause = cause;
        trap_pc    = pc;
        trap_tval  = tval;
        @(negedge clk);
        trap_req = 1'b0;
        wait_redirect(target);
    endtask

    task automatic issue_mret();
        logic [31:0] target;
        target = sh_mepc;
        sh_mstatus[csr_pkg::mstatus_mie]  = sh_mstatus[csr_pkg::mstatus_mpie];
        sh_mstatus[csr_pkg::mstatus_mpie] = 1'b1;
        instr_valid = 1'b1;
        instr       = csr_pkg::mret_instr;
        @(negedge clk);
        instr_valid = 1'b0;
        wait_redirect(target);
    endtask

    task automatic trap_round(input logic [31:0] tvec, input logic [31:0] cause,
                              input logic mie_on);
        logic [31:0] pc;
        logic [31:0] tval;
        pc   = $random(seed);
        tval = $random(seed);
        issue_csr(3'd1, csr_pkg::addr_mtvec, 5'd5, tvec);
        // csrrsi or csrrci on mie decides what the trap stacks into mpie
        issue_csr(mie_on ? 3'd6 : 3'd7, csr_pkg::addr_mstatus, 5'd8, 32'd0);
        drain_reads();
        raise_trap(cause, pc, tval);
        issue_csr(3'd2, csr_pkg::addr_mepc, 5'd0, 32'd0);
        issue_csr(3'd2, csr_pkg::addr_mcause, 5'd0, 32'd0);
        issue_csr(3'd2, csr_pkg::addr_mtval, 5'd0, 32'd0);
        issue_csr(3'd2, csr_pkg::addr_mstatus, 5'd0, 32'd0);
        drain_reads();
        issue_mret();
        issue_csr(3'd2, csr_pkg::addr_mstatus, 5'd0, 32'd0);
        drain_reads();
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] v;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = 32'd0;
        rs1_value   = 32'd0;
        trap_req    = 1'b0;
        trap_cause  = 32'd0;
        trap_pc     = 32'd0;
        trap_tval   = 32'd0;
        sh_mstatus    = {19'd0, csr_pkg::mstatus_mpp_m, 11'd0};
        sh_mie        = 32'd0;
        sh_mtvec      = 32'd0;
        sh_mcounteren = 32'd0;
        sh_mscratch   = 32'd0;
        sh_mepc       = 32'd0;
        sh_mcause     = 32'd0;
        sh_mtval      = 32'd0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // csrrs with x0 reads the reset values without a write
        foreach (id_addrs[k])
            issue_csr(3'd2, id_addrs[k], 5'd0, 32'hffff_ffff);
        drain_reads();

        // back to back rmw on mscratch and mie
        for (int i = 0; i < 48; i++) begin
            r = $random(seed);
            v = $random(seed);
            issue_csr(csr_funct3s[i % 6], r[0] ? csr_pkg::addr_mscratch : csr_pkg::addr_mie,
                      r[5:1], v);
        end
        issue_csr(3'd2, csr_pkg::addr_mscratch, 5'd0, 32'd0);
        issue_csr(3'd2, csr_pkg::addr_mie, 5'd0, 32'd0);
        drain_reads();

        // illegal and read only accesses
        issue_csr(3'd1, 12'h7c0, 5'd3, 32'hdead_beef);
        issue_csr(3'd2, 12'h7c0, 5'd0, 32'd0);
        issue_csr(3'd1, csr_pkg::addr_mhartid, 5'd3, 32'h1234_5678);
        issue_csr(3'd2, csr_pkg::addr_mhartid, 5'd0, 32'hffff_ffff);
        issue_csr(3'd6, csr_pkg::addr_mhartid, 5'd0, 32'd0);
        issue_csr(3'd7, csr_pkg::addr_mvendorid, 5'd1, 32'd0);
        issue_csr(3'd2, csr_pkg::addr_mscratch, 5'd0, 32'd0);
        drain_reads();

        // warl masks
        issue_csr(3'd1, csr_pkg::addr_mepc, 5'd4, 32'hffff_ffff);
        issue_csr(3'd1, csr_pkg::addr_mtvec, 5'd4, 32'hffff_ffff);
        issue_csr(3'd1, csr_pkg::addr_mstatus, 5'd4, 32'hffff_ffff);
        issue_csr(3'd1, csr_pkg::addr_mip, 5'd4, 32'hffff_ffff);
        issue_csr(3'd2, csr_pkg::addr_mepc, 5'd0, 32'd0);
        issue_csr(3'd2, csr_pkg::addr_mtvec, 5'd0, 32'd0);
        issue_csr(3'd2, csr_pkg::addr_mstatus, 5'd0, 32'd0);
        issue_csr(3'd2, csr_pkg::addr_mip, 5'd0, 32'd0);
        issue_csr(3'd1, csr_pkg::addr_mstatus, 5'd4, 32'd0);
        drain_reads();

        // exception then interrupt in direct and then vectored mode
        trap_round(32'h0000_1000, 32'h0000_0002, 1'b1);
        trap_round(32'h0000_1000, 32'h8000_0007, 1'b0);
        trap_round(32'h0000_2003, 32'h0000_000b, 1'b1);
        trap_round(32'h0000_2003, 32'h8000_000b, 1'b0);

        drain_reads();
        repeat (2) @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/csr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module csr_decoder (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             instr_valid,
    input  logic [31:0]      instr,
    input  logic [31:0]      rs1_value,
    output logic             cmd_valid,
    output csr_pkg::csr_op_e cmd_op,
    output logic [11:0]      cmd_addr,
    output logic [31:0]      cmd_operand,
    output logic             cmd_write,
    output logic             mret_pulse
);

    logic             is_system;
    logic [2:0]       funct3;
    logic [4:0]       rs1_field;
    csr_pkg::csr_op_e dec_op;
    logic [31:0]      dec_operand;
    logic             dec_write;
    logic             dec_mret;

    assign is_system = instr_valid && (instr[6:0] == csr_pkg::opcode_system);
    assign funct3    = instr[14:12];
    assign rs1_field = instr[19:15];

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    // funct3[2] picks the immediate form and the low bits pick the operation
    always_comb begin
        dec_op = csr_pkg::op_none;
        if (is_system) begin
            case (funct3[1:0])
                2'b01:   dec_op = csr_pkg::op_rw;
                2'b10:   dec_op = csr_pkg::op_rs;
                2'b11:   dec_op = csr_pkg::op_rc;
                default: dec_op = csr_pkg::op_none;
            endcase
        end
    end

    // zimm sits in the rs1 field
    assign dec_operand = funct3[2] ? {27'd0, rs1_field} : rs1_value;

    // set and clear with x0 or zero zimm are pure reads
    assign dec_write = (dec_op == csr_pkg::op_rw) || (rs1_field != 5'd0);

    assign dec_mret = instr_valid && (instr == csr_pkg::mret_instr);

    ////////////////////////////////////////////////////////////
    // command register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_valid  <= 1'b0;
            mret_pulse <= 1'b0;
        end else begin
            cmd_valid  <= (dec_op != csr_pkg::op_none);
            mret_pulse <= dec_mret;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_op != csr_pkg::op_none) begin
            cmd_op      <= dec_op;
            cmd_addr    <= instr[31:20];
            cmd_operand <= dec_operand;
            cmd_write   <= dec_write;
        end
    end

endmodule

`default_nettype wire

//--- rtl/csr_file.sv
`timescale 1ns/100ps
`default_nettype none

module csr_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cmd_valid,
    input  csr_pkg::csr_op_e              cmd_op,
    input  logic [11:0]                   cmd_addr,
    input  logic [31:0]                   cmd_operand,
    input  logic                          cmd_write,
    input  logic [csr_pkg::trap_we_w-1:0] trap_we,
    input  logic [31:0]                   trap_mepc,
    input  logic [31:0]                   trap_mcause,
    input  logic [31:0]                   trap_mtval,
    input  logic [31:0]                   trap_mstatus,
    output logic [31:0]                   mtvec,
    output logic [31:0]                   mepc,
    output logic [31:0]                   mstatus,
    output logic [31:0]                   rdata,
    output logic                          rdata_valid,
    output logic                          illegal
);

    logic [31:0] mie;
    logic [31:0] mcounteren;
    logic [31:0] mscratch;
    logic [31:0] mcause;
    logic [31:0] mtval;

    logic [31:0] old_value;
    logic        addr_known;
    logic        addr_ro;
    logic        access_bad;
    logic [31:0] wr_data;
    logic        wr_en;

    ////////////////////////////////////////////////////////////
    // address decode and read mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        addr_known = 1'b1;
        addr_ro    = 1'b0;
        case (cmd_addr)
            csr_pkg::addr_mvendorid: begin
                old_value = csr_pkg::mvendorid_val;
                addr_ro   = 1'b1;
            end
            csr_pkg::addr_marchid: begin
                old_value = csr_pkg::marchid_val;
                addr_ro   = 1'b1;
            end
            csr_pkg::addr_mimpid: begin
                old_value = csr_pkg::mimpid_val;
                addr_ro   = 1'b1;
            end
            csr_pkg::addr_mhartid: begin
                old_value = csr_pkg::mhartid_val;
                addr_ro   = 1'b1;
            end
            csr_pkg::addr_mstatus:    old_value = mstatus;
            csr_pkg::addr_misa:       old_value = csr_pkg::misa_val;
            csr_pkg::addr_mie:        old_value = mie;
            csr_pkg::addr_mtvec:      old_value = mtvec;
            csr_pkg::addr_mcounteren: old_value = mcounteren;
            csr_pkg::addr_mscratch:   old_value = mscratch;
            csr_pkg::addr_mepc:       old_value = mepc;
            csr_pkg::addr_mcause:     old_value = mcause;
            csr_pkg::addr_mtval:      old_value = mtval;
            // no pending logic
            csr_pkg::addr_mip:        old_value = 32'd0;
            default: begin
                old_value  = 32'd0;
                addr_known = 1'b0;
            end
        endcase
    end

    assign access_bad = !addr_known || (addr_ro && cmd_write);

    ////////////////////////////////////////////////////////////
    // read-modify-write
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (cmd_op)
            csr_pkg::op_rw: wr_data = cmd_operand;
            csr_pkg::op_rs: wr_data = old_value | cmd_operand;
            csr_pkg::op_rc: wr_data = old_value & ~cmd_operand;
            default:        wr_data = old_value;
        endcase
    end

    assign wr_en = cmd_valid && cmd_write && !access_bad;

    // trap updates are applied after the command write so they win
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus    <= csr_pkg::mstatus_reset;
            mie        <= 32'd0;
            mtvec      <= 32'd0;
            mcounteren <= 32'd0;
            mscratch   <= 32'd0;
            mepc       <= 32'd0;
            mcause     <= 32'd0;
            mtval      <= 32'd0;
        end else begin
            if (wr_en && cmd_addr == csr_pkg::addr_mie)
                mie <= wr_data;
            if (wr_en && cmd_addr == csr_pkg::addr_mtvec)
                mtvec <= wr_data & csr_pkg::mtvec_wmask;
            if (wr_en && cmd_addr == csr_pkg::addr_mcounteren)
                mcounteren <= wr_data;
            if (wr_en && cmd_addr == csr_pkg::addr_mscratch)
                mscratch <= wr_data;

            if (trap_we[csr_pkg::we_mstatus])
                mstatus <= (trap_mstatus & csr_pkg::mstatus_wmask) | csr_pkg::mstatus_reset;
            else if (wr_en && cmd_addr == csr_pkg::addr_mstatus)
                mstatus <= (wr_data & csr_pkg::mstatus_wmask) | csr_pkg::mstatus_reset;

            if (trap_we[csr_pkg::we_mepc])
                mepc <= trap_mepc & csr_pkg::mepc_wmask;
            else if (wr_en && cmd_addr == csr_pkg::addr_mepc)
                mepc <= wr_data & csr_pkg::mepc_wmask;

            if (trap_we[csr_pkg::we_mcause])
                mcause <= trap_mcause;
            else if (wr_en && cmd_addr == csr_pkg::addr_mcause)
                mcause <= wr_data;

            if (trap_we[csr_pkg::we_mtval])
                mtval <= trap_mtval;
            else if (wr_en && cmd_addr == csr_pkg::addr_mtval)
                mtval <= wr_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // registered read-back
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_valid <= 1'b0;
            illegal     <= 1'b0;
        end else begin
            rdata_valid <= cmd_valid;
            illegal     <= cmd_valid && access_bad;
        end
    end

    // old value before this edge's write
    always_ff @(posedge clk) begin
        if (cmd_valid)
            rdata <= access_bad ? 32'd0 : old_value;
    end

endmodule

`default_nettype wire

//--- rtl/csr_pkg.sv
`default_nettype none

package csr_pkg;

    ////////////////////////////////////////////////////////////
    // machine csr addresses
    ////////////////////////////////////////////////////////////

    // read-only information registers
    localparam logic [11:0] addr_mvendorid  = 12'hf11;
    localparam logic [11:0] addr_marchid    = 12'hf12;
    localparam logic [11:0] addr_mimpid     = 12'hf13;
    localparam logic [11:0] addr_mhartid    = 12'hf14;

    // trap setup
    localparam logic [11:0] addr_mstatus    = 12'h300;
    localparam logic [11:0] addr_misa       = 12'h301;
    localparam logic [11:0] addr_mie        = 12'h304;
    localparam logic [11:0] addr_mtvec      = 12'h305;
    localparam logic [11:0] addr_mcounteren = 12'h306;

    // trap handling
    localparam logic [11:0] addr_mscratch   = 12'h340;
    localparam logic [11:0] addr_mepc       = 12'h341;
    localparam logic [11:0] addr_mcause     = 12'h342;
    localparam logic [11:0] addr_mtval      = 12'h343;
    localparam logic [11:0] addr_mip        = 12'h344;

    ////////////////////////////////////////////////////////////
    // constant register values
    ////////////////////////////////////////////////////////////

    localparam logic [31:0] mvendorid_val = 32'h0000_0000;
    localparam logic [31:0] marchid_val   = 32'h0000_0000;
    localparam logic [31:0] mimpid_val    = 32'h0000_0001;
    localparam logic [31:0] mhartid_val   = 32'h0000_0000;

    // mxl of 1 for 32 bit with the base integer isa only
    localparam logic [31:0] misa_val      = 32'h4000_0100;

    ////////////////////////////////////////////////////////////
    // mstatus layout and warl masks
    ////////////////////////////////////////////////////////////

    localparam int mstatus_mie     = 3;
    localparam int mstatus_mpie    = 7;
    localparam int mstatus_mpp_lsb = 11;

    // mpp is hardwired since only machine mode exists
    localparam logic [1:0]  mstatus_mpp_m = 2'b11;
    localparam logic [31:0] mstatus_reset = 32'(mstatus_mpp_m) << mstatus_mpp_lsb;

    localparam logic [31:0] mstatus_wmask = 32'h0000_0088;
    localparam logic [31:0] mtvec_wmask   = 32'hffff_fffd;
    localparam logic [31:0] mepc_wmask    = 32'hffff_fffc;

    ////////////////////////////////////////////////////////////
    // instruction encodings
    ////////////////////////////////////////////////////////////

    localparam logic [6:0]  opcode_system = 7'b111_0011;
    localparam logic [31:0] mret_instr    = 32'h3020_0073;

    // per register enables from the trap controller
    localparam int trap_we_w  = 4;
    localparam int we_mepc    = 0;
    localparam int we_mcause  = 1;
    localparam int we_mtval   = 2;
    localparam int we_mstatus = 3;

    typedef enum logic [1:0] {
        op_none,
        op_rw,
        op_rs,
        op_rc
    } csr_op_e;

endpackage

`default_nettype wire

//--- rtl/csr_trap_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module csr_trap_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          trap_req,
    input  logic [31:0]                   trap_cause,
    input  logic [31:0]                   trap_pc,
    input  logic [31:0]                   trap_tval,
    input  logic                          mret_pulse,
    input  logic [31:0]                   mtvec,
    input  logic [31:0]                   mepc,
    input  logic [31:0]                   mstatus,
    output logic [csr_pkg::trap_we_w-1:0] trap_we,
    output logic [31:0]                   trap_mepc,
    output logic [31:0]                   trap_mcause,
    output logic [31:0]                   trap_mtval,
    output logic [31:0]                   trap_mstatus,
    output logic                          redirect_valid,
    output logic [31:0]                   redirect_pc
);

    logic        trap_pend;
    logic [31:0] pend_cause;
    logic [31:0] pend_pc;
    logic [31:0] pend_tval;
    logic        mret_take;
    logic [31:0] vec_base;
    logic [31:0] trap_target;

    ////////////////////////////////////////////////////////////
    // trap capture
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            trap_pend <= 1'b0;
        else
            trap_pend <= trap_req;
    end

    always_ff @(posedge clk) begin
        if (trap_req) begin
            pend_cause <= trap_cause;
            pend_pc    <= trap_pc;
            pend_tval  <= trap_tval;
        end
    end

    // a trap in the same cycle drops the mret
    assign mret_take = mret_pulse && !trap_pend;

    // vectored mode only for interrupts
    assign vec_base    = {mtvec[31:2], 2'b00};
    assign trap_target = (mtvec[0] && pend_cause[31]) ?
                         vec_base + {pend_cause[29:0], 2'b00} : vec_base;

    ////////////////////////////////////////////////////////////
    // register updates
    ////////////////////////////////////////////////////////////

    always_comb begin
        trap_we      = '0;
        trap_mstatus = mstatus;
        if (trap_pend) begin
            trap_we = '1;
            trap_mstatus[csr_pkg::mstatus_mpie] = mstatus[csr_pkg::mstatus_mie];
            trap_mstatus[csr_pkg::mstatus_mie]  = 1'b0;
        end else if (mret_take) begin
            trap_we[csr_pkg::we_mstatus] = 1'b1;
            trap_mstatus[csr_pkg::mstatus_mie]  = mstatus[csr_pkg::mstatus_mpie];
            trap_mstatus[csr_pkg::mstatus_mpie] = 1'b1;
        end
    end

    assign trap_mepc   = pend_pc;
    assign trap_mcause = pend_cause;
    assign trap_mtval  = pend_tval;

    ////////////////////////////////////////////////////////////
    // redirect
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            redirect_valid <= 1'b0;
        else
            redirect_valid <= trap_pend || mret_take;
    end

    always_ff @(posedge clk) begin
        if (trap_pend)
            redirect_pc <= trap_target;
        else if (mret_take)
            redirect_pc <= mepc;
    end

endmodule

`default_nettype wire

//--- rtl/csr_unit.sv
`timescale 1ns/100ps
`default_nettype none

module csr_unit (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] rs1_value,
    input  logic        trap_req,
    input  logic [31:0] trap_cause,
    input  logic [31:0] trap_pc,
    input  logic [31:0] trap_tval,
    output logic [31:0] rdata,
    output logic        rdata_valid,
    output logic        illegal,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);

    // decoder to csr file
    logic             cmd_valid;
    csr_pkg::csr_op_e cmd_op;
    logic [11:0]      cmd_addr;
    logic [31:0]      cmd_operand;
    logic             cmd_write;
    logic             mret_pulse;

    // trap controller and csr file
    logic [csr_pkg::trap_we_w-1:0] trap_we;
    logic [31:0]                   trap_mepc;
    logic [31:0]                   trap_mcause;
    logic [31:0]                   trap_mtval;
    logic [31:0]                   trap_mstatus;
    logic [31:0]                   mtvec;
    logic [31:0]                   mepc;
    logic [31:0]                   mstatus;

    csr_decoder u_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_value   (rs1_value),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_addr    (cmd_addr),
        .cmd_operand (cmd_operand),
        .cmd_write   (cmd_write),
        .mret_pulse  (mret_pulse)
    );

    csr_file u_file (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_addr     (cmd_addr),
        .cmd_operand  (cmd_operand),
        .cmd_write    (cmd_write),
        .trap_we      (trap_we),
        .trap_mepc    (trap_mepc),
        .trap_mcause  (trap_mcause),
        .trap_mtval   (trap_mtval),
        .trap_mstatus (trap_mstatus),
        .mtvec        (mtvec),
        .mepc         (mepc),
        .mstatus      (mstatus),
        .rdata        (rdata),
        .rdata_valid  (rdata_valid),
        .illegal      (illegal)
    );

    csr_trap_ctrl u_trap_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .trap_req       (trap_req),
        .trap_cause     (trap_cause),
        .trap_pc        (trap_pc),
        .trap_tval      (trap_tval),
        .mret_pulse     (mret_pulse),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .mstatus        (mstatus),
        .trap_we        (trap_we),
        .trap_mepc      (trap_mepc),
        .trap_mcause    (trap_mcause),
        .trap_mtval     (trap_mtval),
        .trap_mstatus   (trap_mstatus),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f src.f --top-module csr_unit_tb -o csr_unit_sim \
    || { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/csr_unit_sim 2>&1)
echo "$out"

echo "$out" | grep -q "TEST RESULT: PASS" && exit 0 || exit 1

//--- src.f
rtl/csr_pkg.sv
rtl/csr_decoder.sv
rtl/csr_file.sv
rtl/csr_trap_ctrl.sv
rtl/csr_unit.sv
dv/csr_unit_tb.sv
